//--- common/bus_defs.svh
// widths, target count and address map shared by the bus fabric
// include wherever a bus width or map constant is needed
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////
`define BUS_AW 16
`define BUS_DW 32
`define BUS_IW 4

//////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////
// four targets, decode vectors carry one extra none-selected bit
`define BUS_NT 4
// bits 15:12 pick the target
`define BUS_SEL_MASK 16'hF000
// target k sits at k times this stride
`define BUS_TGT_STRIDE 16'h1000
// per-direction access masks, target 3 is read only
`define BUS_WR_ALLOWED 4'b0111
`define BUS_RD_ALLOWED 4'b1111

//////////////////////////////////////////////////
// target memories
//////////////////////////////////////////////////
// words per target, indexed by address bits 5:2
`define BUS_MEM_WORDS 16
// rom word i reads back as this value plus i
`define BUS_ROM_BASE_WORD 32'hC0DE0000

`endif

//--- common/bus_pkg.sv
// types shared by the router, the targets and the top level
// import inside a module body, or use scoped names in port lists

package bus_pkg;

    // response codes returned on both response channels
    // slverr is reserved, nothing in the fabric produces it
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // operation carried from the router to a target
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // router FSM
    // idle takes a request, wait holds for target done, resp holds the reply
    typedef enum logic [1:0] {
        RT_IDLE = 2'b00,
        RT_WAIT = 2'b01,
        RT_RESP = 2'b10
    } rt_state_e;

endpackage

//--- addr_decode/addr_decode.sv
// registered address decoder with a valid/stall handshake
// one instance per request channel; ACCESS_ALLOWED masks out targets
// that this channel may not reach, which then decode as none-selected
`timescale 1ns/1ps
`include "bus_defs.svh"

module addr_decode #(
    parameter logic [`BUS_NT-1:0] ACCESS_ALLOWED = '1
) (
    input  logic                clock,
    input  logic                reset,
    // upstream request
    input  logic                i_valid,
    output logic                o_stall,
    input  logic [`BUS_AW-1:0]  i_addr,
    input  logic [`BUS_IW-1:0]  i_id,
    input  logic [`BUS_DW-1:0]  i_data,
    // decoded request toward the router
    output logic                o_valid,
    input  logic                i_stall,
    output logic [`BUS_NT:0]    o_decode,
    output logic [`BUS_AW-1:0]  o_addr,
    output logic [`BUS_IW-1:0]  o_id,
    output logic [`BUS_DW-1:0]  o_data
);

    // per-target match, already gated by the access mask
    logic [`BUS_NT-1:0] match;
    // one-hot request, top bit set when no permitted target matched
    logic [`BUS_NT:0]   request;
    // base address of the target under test in the loop
    logic [`BUS_AW-1:0] base;
    // request moves into the output register this cycle
    logic               accept;

    //////////////////////////////////////////////////
    // address compare
    //////////////////////////////////////////////////

    always_comb begin
        base = '0;
        for (int k = 0; k < `BUS_NT; k++) begin
            base = `BUS_AW'(k) * `BUS_TGT_STRIDE;
            // only the select bits take part in the compare
            match[k] = (((i_addr ^ base) & `BUS_SEL_MASK) == '0) && ACCESS_ALLOWED[k];
        end
        // nothing is requested at all when the input is idle
        request[`BUS_NT-1:0] = i_valid ? match : '0;
        // unmapped or disallowed, router answers with a decode error
        request[`BUS_NT] = i_valid && (match == '0);
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    // held item blocks upstream only while the router stalls it
    // so a new item can enter on the same edge the old one leaves
    assign o_stall = o_valid && i_stall;
    assign accept  = i_valid && !o_stall;

    always_ff @(posedge clock) begin
        if (!reset) begin
            o_valid <= 1'b0;
        end else if (!o_stall) begin
            o_valid <= i_valid;
        end
    end

    // decode bits drop to zero whenever the register empties
    always_ff @(posedge clock) begin
        if (!reset) begin
            o_decode <= '0;
        end else if (!o_stall) begin
            o_decode <= request;
        end
    end

    // payload only changes when a new request is taken
    always_ff @(posedge clock) begin
        if (accept) begin
            o_addr <= i_addr;
            o_id   <= i_id;
            // write data rides along here, the read side ties it low
            o_data <= i_data;
        end
    end

endmodule

//--- bus_router/bus_router.sv
// single-outstanding router between the two decoders and the targets
// alternates read/write priority, issues one request, returns the reply
// on the matching response channel; unmapped requests get a decode error
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_router (
    input  logic                               clock,
    input  logic                               reset,
    // decoded write requests
    input  logic                               i_wr_valid,
    output logic                               o_wr_stall,
    input  logic [`BUS_NT:0]                   i_wr_decode,
    input  logic [`BUS_AW-1:0]                 i_wr_addr,
    input  logic [`BUS_IW-1:0]                 i_wr_id,
    input  logic [`BUS_DW-1:0]                 i_wr_data,
    // decoded read requests
    input  logic                               i_rd_valid,
    output logic                               o_rd_stall,
    input  logic [`BUS_NT:0]                   i_rd_decode,
    input  logic [`BUS_AW-1:0]                 i_rd_addr,
    input  logic [`BUS_IW-1:0]                 i_rd_id,
    // target side
    output logic [`BUS_NT-1:0]                 o_tgt_valid,
    output bus_pkg::op_e                       o_tgt_op,
    output logic [`BUS_AW-1:0]                 o_tgt_addr,
    output logic [`BUS_DW-1:0]                 o_tgt_wdata,
    output logic [`BUS_IW-1:0]                 o_tgt_id,
    input  logic [`BUS_NT-1:0]                 i_tgt_done,
    input  logic [`BUS_NT-1:0][`BUS_DW-1:0]    i_tgt_rdata,
    input  logic [`BUS_NT-1:0][`BUS_IW-1:0]    i_tgt_rid,
    // write response
    output logic                               o_bresp_valid,
    input  logic                               i_bresp_stall,
    output logic [`BUS_IW-1:0]                 o_bresp_id,
    output bus_pkg::resp_e                     o_bresp_code,
    // read response
    output logic                               o_rresp_valid,
    input  logic                               i_rresp_stall,
    output logic [`BUS_IW-1:0]                 o_rresp_id,
    output bus_pkg::resp_e                     o_rresp_code,
    output logic [`BUS_DW-1:0]                 o_rresp_data
);
    import bus_pkg::*;

    rt_state_e          state;
    // 1 when the previous grant went to the write channel
    logic               last_wr;
    // 1 while the transaction in service came from the write channel
    logic               cur_wr;
    logic               grant_wr;
    logic               grant_rd;
    logic               take;
    logic               resp_accept;
    logic [`BUS_NT:0]   sel_decode;
    // reply being built or held
    logic [`BUS_IW-1:0] resp_id;
    resp_e              resp_code;
    logic [`BUS_DW-1:0] resp_data;
    // reply picked from whichever target finished
    logic [`BUS_DW-1:0] done_data;
    logic [`BUS_IW-1:0] done_id;

    //////////////////////////////////////////////////
    // arbitration and issue
    //////////////////////////////////////////////////

    // on a tie the channel not served last wins
    assign grant_wr = i_wr_valid && (!i_rd_valid || !last_wr);
    assign grant_rd = i_rd_valid && !grant_wr;
    assign take     = (state == RT_IDLE) && (grant_wr || grant_rd);

    // decoders hold their item unless it is taken this cycle
    assign o_wr_stall = !((state == RT_IDLE) && grant_wr);
    assign o_rd_stall = !((state == RT_IDLE) && grant_rd);

    assign sel_decode = grant_wr ? i_wr_decode : i_rd_decode;

    // one-cycle pulse to the decoded target, never to none-selected
    assign o_tgt_valid = take ? sel_decode[`BUS_NT-1:0] : '0;
    assign o_tgt_op    = grant_wr ? OP_WRITE : OP_READ;
    assign o_tgt_addr  = grant_wr ? i_wr_addr : i_rd_addr;
    assign o_tgt_wdata = grant_wr ? i_wr_data : '0;
    assign o_tgt_id    = grant_wr ? i_wr_id : i_rd_id;

    // only one target can be busy, so at most one done bit is set
    always_comb begin
        done_data = '0;
        done_id   = '0;
        for (int k = 0; k < `BUS_NT; k++) begin
            if (i_tgt_done[k]) begin
                done_data = i_tgt_rdata[k];
                done_id   = i_tgt_rid[k];
            end
        end
    end

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    assign resp_accept = cur_wr ? !i_bresp_stall : !i_rresp_stall;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= RT_IDLE;
            last_wr <= 1'b0;
            cur_wr  <= 1'b0;
        end else begin
            case (state)
                RT_IDLE: begin
                    if (take) begin
                        last_wr <= grant_wr;
                        cur_wr  <= grant_wr;
                        // unmapped requests skip the target entirely
                        state   <= sel_decode[`BUS_NT] ? RT_RESP : RT_WAIT;
                    end
                end
                RT_WAIT: begin
                    if (|i_tgt_done) begin
                        state <= RT_RESP;
                    end
                end
                RT_RESP: begin
                    if (resp_accept) begin
                        state <= RT_IDLE;
                    end
                end
                default: state <= RT_IDLE;
            endcase
        end
    end

    // reply fields, seeded on take and filled in by the target
    always_ff @(posedge clock) begin
        if (take) begin
            resp_id   <= o_tgt_id;
            resp_code <= sel_decode[`BUS_NT] ? RESP_DECERR : RESP_OKAY;
            resp_data <= '0;
        end else if ((state == RT_WAIT) && |i_tgt_done) begin
            resp_id   <= done_id;
            resp_data <= done_data;
        end
    end

    //////////////////////////////////////////////////
    // response channels
    //////////////////////////////////////////////////

    assign o_bresp_valid = (state == RT_RESP) && cur_wr;
    assign o_bresp_id    = resp_id;
    assign o_bresp_code  = resp_code;
    assign o_rresp_valid = (state == RT_RESP) && !cur_wr;
    assign o_rresp_id    = resp_id;
    assign o_rresp_code  = resp_code;
    assign o_rresp_data  = resp_data;

endmodule

//--- src/mem_target.sv
// word-addressed memory target with a fixed reply latency
// RAM clears at reset; with IS_ROM set it loads the rom pattern and ignores writes
`timescale 1ns/1ps
`include "bus_defs.svh"

module mem_target #(
    parameter int LATENCY = 1,
    parameter bit IS_ROM  = 1'b0
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               i_valid,
    input  bus_pkg::op_e       i_op,
    input  logic [`BUS_AW-1:0] i_addr,
    input  logic [`BUS_DW-1:0] i_wdata,
    input  logic [`BUS_IW-1:0] i_id,
    output logic               o_done,
    output logic [`BUS_DW-1:0] o_rdata,
    output logic [`BUS_IW-1:0] o_id
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(`BUS_MEM_WORDS);

    logic [`BUS_DW-1:0] mem [`BUS_MEM_WORDS];
    // word index from address bits 5:2
    logic [IDX_W-1:0]   idx;
    // reply pipeline, stage LATENCY-1 drives the outputs
    logic [LATENCY-1:0] done_sr;
    logic [`BUS_DW-1:0] data_sr [LATENCY];
    logic [`BUS_IW-1:0] id_sr [LATENCY];

    assign idx = i_addr[IDX_W+1:2];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `BUS_MEM_WORDS; i++) begin
                mem[i] <= IS_ROM ? `BUS_ROM_BASE_WORD + `BUS_DW'(i) : '0;
            end
        end else if (i_valid && (i_op == OP_WRITE) && !IS_ROM) begin
            mem[idx] <= i_wdata;
        end
    end

    //////////////////////////////////////////////////
    // reply delay line
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            done_sr <= '0;
        end else begin
            done_sr[0] <= i_valid;
            for (int s = 1; s < LATENCY; s++) begin
                done_sr[s] <= done_sr[s-1];
            end
        end
    end

    // writes answer with zero data
    always_ff @(posedge clock) begin
        data_sr[0] <= (i_op == OP_READ) ? mem[idx] : '0;
        id_sr[0]   <= i_id;
        for (int s = 1; s < LATENCY; s++) begin
            data_sr[s] <= data_sr[s-1];
            id_sr[s]   <= id_sr[s-1];
        end
    end

    assign o_done  = done_sr[LATENCY-1];
    assign o_rdata = data_sr[LATENCY-1];
    assign o_id    = id_sr[LATENCY-1];

endmodule

//--- src/bus_fabric_top.sv
// top level of the bus fabric
// write and read decoders feed the router, which drives four memory targets
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_fabric_top (
    input  logic               clock,
    input  logic               reset,
    // write request
    input  logic               i_wr_valid,
    output logic               o_wr_stall,
    input  logic [`BUS_AW-1:0] i_wr_addr,
    input  logic [`BUS_IW-1:0] i_wr_id,
    input  logic [`BUS_DW-1:0] i_wr_data,
    // read request
    input  logic               i_rd_valid,
    output logic               o_rd_stall,
    input  logic [`BUS_AW-1:0] i_rd_addr,
    input  logic [`BUS_IW-1:0] i_rd_id,
    // write response
    output logic               o_bresp_valid,
    input  logic               i_bresp_stall,
    output logic [`BUS_IW-1:0] o_bresp_id,
    output bus_pkg::resp_e     o_bresp_code,
    // read response
    output logic               o_rresp_valid,
    input  logic               i_rresp_stall,
    output logic [`BUS_IW-1:0] o_rresp_id,
    output bus_pkg::resp_e     o_rresp_code,
    output logic [`BUS_DW-1:0] o_rresp_data
);
    import bus_pkg::*;

    // decoded write channel
    logic                            wr_valid, wr_stall;
    logic [`BUS_NT:0]                wr_decode;
    logic [`BUS_AW-1:0]              wr_addr;
    logic [`BUS_IW-1:0]              wr_id;
    logic [`BUS_DW-1:0]              wr_data;
    // decoded read channel
    logic                            rd_valid, rd_stall;
    logic [`BUS_NT:0]                rd_decode;
    logic [`BUS_AW-1:0]              rd_addr;
    logic [`BUS_IW-1:0]              rd_id;
    // shared target bus
    logic [`BUS_NT-1:0]              tgt_valid, tgt_done;
    op_e                             tgt_op;
    logic [`BUS_AW-1:0]              tgt_addr;
    logic [`BUS_DW-1:0]              tgt_wdata;
    logic [`BUS_IW-1:0]              tgt_id;
    logic [`BUS_NT-1:0][`BUS_DW-1:0] tgt_rdata;
    logic [`BUS_NT-1:0][`BUS_IW-1:0] tgt_rid;

    //////////////////////////////////////////////////
    // decoders
    //////////////////////////////////////////////////

    // write data is carried as decoder payload
    addr_decode #(.ACCESS_ALLOWED(`BUS_WR_ALLOWED)) u_wr_decode (
        .clock, .reset,
        .i_valid(i_wr_valid), .o_stall(o_wr_stall), .i_addr(i_wr_addr),
        .i_id(i_wr_id), .i_data(i_wr_data),
        .o_valid(wr_valid), .i_stall(wr_stall), .o_decode(wr_decode),
        .o_addr(wr_addr), .o_id(wr_id), .o_data(wr_data)
    );

    // reads carry no data
    addr_decode #(.ACCESS_ALLOWED(`BUS_RD_ALLOWED)) u_rd_decode (
        .clock, .reset,
        .i_valid(i_rd_valid), .o_stall(o_rd_stall), .i_addr(i_rd_addr),
        .i_id(i_rd_id), .i_data('0),
        .o_valid(rd_valid), .i_stall(rd_stall), .o_decode(rd_decode),
        .o_addr(rd_addr), .o_id(rd_id), .o_data()
    );

    //////////////////////////////////////////////////
    // router
    //////////////////////////////////////////////////

    bus_router u_router (
        .clock, .reset,
        .i_wr_valid(wr_valid), .o_wr_stall(wr_stall), .i_wr_decode(wr_decode),
        .i_wr_addr(wr_addr), .i_wr_id(wr_id), .i_wr_data(wr_data),
        .i_rd_valid(rd_valid), .o_rd_stall(rd_stall), .i_rd_decode(rd_decode),
        .i_rd_addr(rd_addr), .i_rd_id(rd_id),
        .o_tgt_valid(tgt_valid), .o_tgt_op(tgt_op), .o_tgt_addr(tgt_addr),
        .o_tgt_wdata(tgt_wdata), .o_tgt_id(tgt_id),
        .i_tgt_done(tgt_done), .i_tgt_rdata(tgt_rdata), .i_tgt_rid(tgt_rid),
        .o_bresp_valid, .i_bresp_stall, .o_bresp_id, .o_bresp_code,
        .o_rresp_valid, .i_rresp_stall, .o_rresp_id, .o_rresp_code, .o_rresp_data
    );

    //////////////////////////////////////////////////
    // targets, latency 1 to 4, the last one is rom
    //////////////////////////////////////////////////

    mem_target #(.LATENCY(1), .IS_ROM(1'b0)) u_tgt0 (
        .clock, .reset, .i_valid(tgt_valid[0]), .i_op(tgt_op), .i_addr(tgt_addr),
        .i_wdata(tgt_wdata), .i_id(tgt_id),
        .o_done(tgt_done[0]), .o_rdata(tgt_rdata[0]), .o_id(tgt_rid[0])
    );

    mem_target #(.LATENCY(2), .IS_ROM(1'b0)) u_tgt1 (
        .clock, .reset, .i_valid(tgt_valid[1]), .i_op(tgt_op), .i_addr(tgt_addr),
        .i_wdata(tgt_wdata), .i_id(tgt_id),
        .o_done(tgt_done[1]), .o_rdata(tgt_rdata[1]), .o_id(tgt_rid[1])
    );

    mem_target #(.LATENCY(3), .IS_ROM(1'b0)) u_tgt2 (
        .clock, .reset, .i_valid(tgt_valid[2]), .i_op(tgt_op), .i_addr(tgt_addr),
        .i_wdata(tgt_wdata), .i_id(tgt_id),
        .o_done(tgt_done[2]), .o_rdata(tgt_rdata[2]), .o_id(tgt_rid[2])
    );

    mem_target #(.LATENCY(4), .IS_ROM(1'b1)) u_tgt3 (
        .clock, .reset, .i_valid(tgt_valid[3]), .i_op(tgt_op), .i_addr(tgt_addr),
        .i_wdata(tgt_wdata), .i_id(tgt_id),
        .o_done(tgt_done[3]), .o_rdata(tgt_rdata[3]), .o_id(tgt_rid[3])
    );

endmodule

//--- verif/bus_fabric_assert.sv
// concurrent checks on the request handshakes, decode vectors and target issue
// bound into the fabric top level
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_fabric_assert (
    input logic               clock,
    input logic               reset,
    // outside request channels
    input logic               i_wr_valid, i_wr_stall, i_rd_valid, i_rd_stall,
    // decoder outputs toward the router
    input logic               i_wdec_valid, i_wdec_stall,
    input logic [`BUS_NT:0]   i_wdec_decode,
    input logic [`BUS_AW-1:0] i_wdec_addr,
    input logic [`BUS_IW-1:0] i_wdec_id,
    input logic [`BUS_DW-1:0] i_wdec_data,
    input logic               i_rdec_valid, i_rdec_stall,
    input logic [`BUS_NT:0]   i_rdec_decode,
    input logic [`BUS_AW-1:0] i_rdec_addr,
    input logic [`BUS_IW-1:0] i_rdec_id,
    input logic [`BUS_NT-1:0] i_tgt_valid,
    input logic               i_bresp_valid, i_rresp_valid
);

    // read by the testbench at the end of the run
    int   fail_count = 0;
    // set once any request has entered a decoder
    logic seen_req;

    always_ff @(posedge clock) begin
        if (!reset) begin
            seen_req <= 1'b0;
        end else if ((i_wr_valid && !i_wr_stall) || (i_rd_valid && !i_rd_stall)) begin
            seen_req <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // properties
    //////////////////////////////////////////////////

    wr_hold: assert property (@(posedge clock) disable iff (!reset)
        i_wdec_valid && i_wdec_stall |=> i_wdec_valid &&
            $stable({i_wdec_decode, i_wdec_addr, i_wdec_id, i_wdec_data}))
        else begin fail_count++; $error("write request changed while stalled"); end

    rd_hold: assert property (@(posedge clock) disable iff (!reset)
        i_rdec_valid && i_rdec_stall |=> i_rdec_valid &&
            $stable({i_rdec_decode, i_rdec_addr, i_rdec_id}))
        else begin fail_count++; $error("read request changed while stalled"); end

    // the none-selected bit counts as one of the hot positions
    wr_onehot: assert property (@(posedge clock) disable iff (!reset)
        i_wdec_valid |-> $onehot(i_wdec_decode))
        else begin fail_count++; $error("write decode not one-hot"); end

    rd_onehot: assert property (@(posedge clock) disable iff (!reset)
        i_rdec_valid |-> $onehot(i_rdec_decode))
        else begin fail_count++; $error("read decode not one-hot"); end

    tgt_single: assert property (@(posedge clock) disable iff (!reset)
        $onehot0(i_tgt_valid))
        else begin fail_count++; $error("more than one target valid"); end

    no_early_resp: assert property (@(posedge clock) disable iff (!reset)
        !seen_req |-> !(i_bresp_valid || i_rresp_valid))
        else begin fail_count++; $error("response valid before any request"); end

endmodule

bind bus_fabric_top bus_fabric_assert u_assert (
    .clock, .reset,
    .i_wr_valid, .i_wr_stall(o_wr_stall), .i_rd_valid, .i_rd_stall(o_rd_stall),
    .i_wdec_valid(wr_valid), .i_wdec_stall(wr_stall), .i_wdec_decode(wr_decode),
    .i_wdec_addr(wr_addr), .i_wdec_id(wr_id), .i_wdec_data(wr_data),
    .i_rdec_valid(rd_valid), .i_rdec_stall(rd_stall), .i_rdec_decode(rd_decode),
    .i_rdec_addr(rd_addr), .i_rdec_id(rd_id),
    .i_tgt_valid(tgt_valid),
    .i_bresp_valid(o_bresp_valid), .i_rresp_valid(o_rresp_valid)
);

//--- verif/tb_bus_fabric.sv
// directed testbench for the bus fabric
// drives both request channels and checks every response against a small model
// of the address map and the three RAM targets
`timescale 1ns/1ps
`include "bus_defs.svh"

module tb_bus_fabric;
    import bus_pkg::*;

    // about 125 transactions at up to 7 cycles each plus the stall window
    localparam int MAX_CYCLES = 2000;

    logic               clock;
    logic               reset;
    logic               i_wr_valid, o_wr_stall, i_rd_valid, o_rd_stall;
    logic [`BUS_AW-1:0] i_wr_addr, i_rd_addr;
    logic [`BUS_IW-1:0] i_wr_id, i_rd_id, o_bresp_id, o_rresp_id;
    logic [`BUS_DW-1:0] i_wr_data, o_rresp_data;
    logic               o_bresp_valid, i_bresp_stall, o_rresp_valid, i_rresp_stall;
    resp_e              o_bresp_code, o_rresp_code;

    int                 seed = 55745;
    int                 cycles = 0;
    int                 wr_count = 0;
    int                 rd_count = 0;
    // expected responses per channel in request order
    logic [`BUS_IW-1:0] exp_b_id[$], exp_r_id[$];
    resp_e              exp_b_code[$], exp_r_code[$];
    logic [`BUS_DW-1:0] exp_r_data[$];
    // model of RAM targets 0 to 2
    logic [`BUS_DW-1:0] shadow [3][`BUS_MEM_WORDS];

    bus_fabric_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error($sformatf("timeout, run did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    // responses are sampled mid-cycle and only when the channel accepts them
    always @(negedge clock) begin
        if (reset && o_bresp_valid && !i_bresp_stall) begin
            if (exp_b_id.size() == 0) begin
                stop_on_error("write response arrived with no write outstanding");
            end else begin
                check_eq("o_bresp_id", 32'(o_bresp_id), 32'(exp_b_id.pop_front()));
                check_eq("o_bresp_code", 32'(o_bresp_code), 32'(exp_b_code.pop_front()));
            end
        end
        if (reset && o_rresp_valid && !i_rresp_stall) begin
            if (exp_r_id.size() == 0) begin
                stop_on_error("read response arrived with no read outstanding");
            end else begin
                check_eq("o_rresp_id", 32'(o_rresp_id), 32'(exp_r_id.pop_front()));
                check_eq("o_rresp_code", 32'(o_rresp_code), 32'(exp_r_code.pop_front()));
                check_eq("o_rresp_data", o_rresp_data, exp_r_data.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // channel drivers
    //////////////////////////////////////////////////

    function automatic logic [`BUS_AW-1:0] word_addr(input int tgt, input int word);
        return `BUS_AW'(tgt * 'h1000 + word * 4);
    endfunction

    // called 1 ns after a rising edge and returns 1 ns after the transfer edge
    task automatic write_word(input logic [`BUS_AW-1:0] addr, input logic [`BUS_DW-1:0] data,
                              input resp_e code);
        logic [`BUS_IW-1:0] id;
        id = `BUS_IW'(wr_count);
        wr_count++;
        exp_b_id.push_back(id);
        exp_b_code.push_back(code);
        i_wr_valid = 1'b1;
        i_wr_addr  = addr;
        i_wr_id    = id;
        i_wr_data  = data;
        @(negedge clock);
        while (o_wr_stall) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        i_wr_valid = 1'b0;
    endtask

    task automatic read_word(input logic [`BUS_AW-1:0] addr, input resp_e code,
                             input logic [`BUS_DW-1:0] data);
        logic [`BUS_IW-1:0] id;
        id = `BUS_IW'(rd_count + 8);
        rd_count++;
        exp_r_id.push_back(id);
        exp_r_code.push_back(code);
        exp_r_data.push_back(data);
        i_rd_valid = 1'b1;
        i_rd_addr  = addr;
        i_rd_id    = id;
        @(negedge clock);
        while (o_rd_stall) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        i_rd_valid = 1'b0;
    endtask

    // wait until every issued request has been answered
    task automatic wait_drained();
        do begin
            @(posedge clock);
        end while (exp_b_id.size() != 0 || exp_r_id.size() != 0);
        #1;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_state_check();
        @(negedge clock);
        check_eq("o_bresp_valid", 32'(o_bresp_valid), 0);
        check_eq("o_rresp_valid", 32'(o_rresp_valid), 0);
        check_eq("o_wr_stall", 32'(o_wr_stall), 0);
        check_eq("o_rd_stall", 32'(o_rd_stall), 0);
        @(posedge clock);
        #1;
    endtask

    task automatic ram_write_read();
        logic [`BUS_DW-1:0] data;
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < `BUS_MEM_WORDS; w++) begin
                data = $random(seed);
                shadow[t][w] = data;
                write_word(word_addr(t, w), data, RESP_OKAY);
                wait_drained();
            end
        end
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < `BUS_MEM_WORDS; w++) begin
                read_word(word_addr(t, w), RESP_OKAY, shadow[t][w]);
                wait_drained();
            end
        end
    endtask

    task automatic rom_access();
        for (int w = 0; w < `BUS_MEM_WORDS; w++) begin
            read_word(word_addr(3, w), RESP_OKAY, `BUS_ROM_BASE_WORD + `BUS_DW'(w));
            wait_drained();
        end
        // target 3 sits outside the write mask
        write_word(word_addr(3, 5), 32'h1234_5678, RESP_DECERR);
        wait_drained();
        read_word(word_addr(3, 5), RESP_OKAY, `BUS_ROM_BASE_WORD + 32'd5);
        wait_drained();
    endtask

    task automatic unmapped_access();
        write_word(16'h4000, 32'hDEAD_BEEF, RESP_DECERR);
        wait_drained();
        read_word(16'h8004, RESP_DECERR, '0);
        wait_drained();
        read_word(16'hF00C, RESP_DECERR, '0);
        wait_drained();
    endtask

    task automatic backpressure_run();
        logic [`BUS_DW-1:0] d1;
        logic [`BUS_DW-1:0] d2;
        d1 = $random(seed);
        d2 = $random(seed);
        shadow[1][3] = d1;
        shadow[2][7] = d2;
        i_bresp_stall = 1'b1;
        i_rresp_stall = 1'b1;
        fork
            begin
                write_word(word_addr(1, 3), d1, RESP_OKAY);
                write_word(word_addr(2, 7), d2, RESP_OKAY);
                write_word(word_addr(3, 0), d1, RESP_DECERR);
            end
            begin
                read_word(word_addr(3, 2), RESP_OKAY, `BUS_ROM_BASE_WORD + 32'd2);
                read_word(word_addr(0, 5), RESP_OKAY, shadow[0][5]);
                read_word(16'h5000, RESP_DECERR, '0);
            end
            begin
                // router parks in RT_RESP while both decoders fill behind it
                repeat (12) @(posedge clock);
                @(negedge clock);
                check_eq("o_wr_stall", 32'(o_wr_stall), 1);
                check_eq("o_rd_stall", 32'(o_rd_stall), 1);
                check_eq("o_bresp_valid | o_rresp_valid", 32'(o_bresp_valid | o_rresp_valid), 1);
                @(posedge clock);
                #1;
                i_bresp_stall = 1'b0;
                i_rresp_stall = 1'b0;
            end
        join
        wait_drained();
        // read back the two writes that waited behind the held responses
        read_word(word_addr(1, 3), RESP_OKAY, shadow[1][3]);
        wait_drained();
        read_word(word_addr(2, 7), RESP_OKAY, shadow[2][7]);
        wait_drained();
    endtask

    initial begin
        reset         = 1'b0;
        i_wr_valid    = 1'b0;
        i_wr_addr     = '0;
        i_wr_id       = '0;
        i_wr_data     = '0;
        i_rd_valid    = 1'b0;
        i_rd_addr     = '0;
        i_rd_id       = '0;
        i_bresp_stall = 1'b0;
        i_rresp_stall = 1'b0;
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < `BUS_MEM_WORDS; w++) begin
                shadow[t][w] = '0;
            end
        end
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b1;
        reset_state_check();
        ram_write_read();
        rom_access();
        unmapped_access();
        backpressure_run();
        if (u_dut.u_assert.fail_count != 0) begin
            stop_on_error($sformatf("%0d assertion failures in the bound checker",
                                    u_dut.u_assert.fail_count));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+common
common/bus_pkg.sv
addr_decode/addr_decode.sv
bus_router/bus_router.sv
src/mem_target.sv
src/bus_fabric_top.sv
verif/bus_fabric_assert.sv
verif/tb_bus_fabric.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_bus_fabric
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
